// ==== xgmii_tx.f ====
+incdir+hw
hw/eth_tx_pkg.sv
hw/fcs_if.sv
hw/eth_fcs_gen.sv
hw/eth_tx_fsm.sv
hw/xgmii_tx.sv
sim/xgmii_tx_assertions.sv
sim/xgmii_tx_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module xgmii_tx_tb -f xgmii_tx.f -o sim_xgmii_tx
./obj_dir/sim_xgmii_tx > sim.log 2>&1 || true
cat sim.log

if grep -q "=== FAIL ===" sim.log || ! grep -q "=== PASS ===" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"

// ==== sim/xgmii_tx_tb.sv ====
// clock, reset, LFSR, reference CRC and frame model, compare tasks, directed tests and watchdog
`include "eth_tx_consts.svh"

module xgmii_tx_tb import eth_tx_pkg::*; ();

    localparam int PERIOD = 40;
    localparam int NUM_FRAMES = 11;
    // frame with preamble and FCS stays within 80 bytes and its gap within 24
    localparam int WATCHDOG_CYCLES = 10 + 40 + NUM_FRAMES * (80 + 24) / 4 + 400;

    logic        clk;
    logic        reset_crc;
    logic [31:0] tx_tdata;
    logic [3:0]  tx_tkeep;
    logic        tx_tvalid;
    logic        tx_tlast;
    logic        tx_tuser;
    logic        tx_tready;
    logic [7:0]  cfg_tx_ifg;
    logic        cfg_tx_enable;
    logic [31:0] xgmii_txd;
    logic [3:0]  xgmii_txc;
    logic        tx_start_packet;
    logic        stat_tx_pkt_good;
    logic        stat_tx_pkt_bad;
    logic [15:0] stat_tx_pkt_len;

    logic [31:0] lfsr = 32'h5a4e;

    // monitor results for the latest frame
    logic [7:0]  rx_q[$];
    bit          in_frame = 1'b0;
    int          frames_seen = 0;
    int          pos = 0;
    int          term_pos = 0;
    int          last_gap = 0;
    int          start_count = 0;
    int          start_at = 0;
    int          end_lane;
    xgmii_ctrl_t end_ctrl;
    logic [31:0] end_word;
    logic        end_good;
    logic        end_bad;
    logic [15:0] end_len;

    xgmii_tx UUT (.*);

    always #(PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic next_byte(output logic [7:0] b);
        for (int i = 0; i < 8; i++) begin
            lfsr = lfsr_step(lfsr);
            b[i] = lfsr[0];
        end
    endtask

    function automatic logic [31:0] crc32(input logic [7:0] q[$]);
        logic [31:0] crc;
        crc = 32'hffffffff;
        foreach (q[k]) begin
            for (int i = 0; i < 8; i++) begin
                crc = (crc >> 1) ^ ((crc[0] ^ q[k][i]) ? `ETH_CRC_POLY : 32'd0);
            end
        end
        return ~crc;
    endfunction

    // payload and zero pad followed by the FCS low byte first
    task automatic model_frame(input logic [7:0] pay[$], output logic [7:0] frm[$]);
        logic [31:0] crc;
        frm = pay;
        while (frm.size() < `ETH_MIN_FRAME_LEN - 4) begin
            frm.push_back(8'h00);
        end
        crc = crc32(frm);
        for (int k = 0; k < 4; k++) begin
            frm.push_back(crc[k*8 +: 8]);
        end
    endtask

    task automatic fail_now(input string what);
        $display("%s", what);
        $display("=== FAIL ===");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) fail_now($sformatf("FAIL %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_ctrl(input string name, input xgmii_ctrl_t got, input xgmii_ctrl_t exp);
        if (got !== exp) fail_now($sformatf("FAIL %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_len(input string name, input logic [15:0] got, input logic [15:0] exp);
        if (got !== exp) fail_now($sformatf("FAIL %s got %h expected %h", name, got, exp));
    endtask

    // walks the lanes in byte order
    always @(negedge clk) begin
        if (!reset_crc) begin
            if (tx_start_packet) begin
                start_count++;
                start_at = rx_q.size();
            end
            for (int l = 0; l < 4; l++) begin
                if (in_frame && xgmii_txc[l]) begin
                    in_frame = 1'b0;
                    end_ctrl = xgmii_ctrl_t'(xgmii_txd[l*8 +: 8]);
                    end_lane = l;
                    end_word = xgmii_txd;
                    end_good = stat_tx_pkt_good;
                    end_bad = stat_tx_pkt_bad;
                    end_len = stat_tx_pkt_len;
                    term_pos = pos;
                    frames_seen++;
                end else if (in_frame) begin
                    rx_q.push_back(xgmii_txd[l*8 +: 8]);
                end else if (xgmii_txc[l] && xgmii_txd[l*8 +: 8] == `XGMII_START) begin
                    in_frame = 1'b1;
                    rx_q.delete();
                    start_count = 0;
                    last_gap = pos - term_pos - 1;
                end
                pos++;
            end
        end
    end

    // starts just after a falling edge and returns once the last beat is taken
    task automatic send_frame(input logic [7:0] data[$], input bit user, input int drop_at);
        int  nbeats;
        int  i;
        bit  accepted;
        bit  dropped;
        nbeats = (data.size() + 3) / 4;
        i = 0;
        dropped = 1'b0;
        while (i < nbeats) begin
            for (int l = 0; l < 4; l++) begin
                tx_tkeep[l] = (i * 4 + l < data.size());
                tx_tdata[l*8 +: 8] = tx_tkeep[l] ? data[i*4 + l] : 8'hee;
            end
            tx_tlast = (i == nbeats - 1);
            tx_tuser = user && (i == nbeats - 1);
            if (i == drop_at && !dropped) begin
                tx_tvalid = 1'b0;
                dropped = 1'b1;
                accepted = 1'b0;
            end else begin
                tx_tvalid = 1'b1;
                accepted = tx_tready;
            end
            @(negedge clk);
            if (accepted) i++;
        end
        tx_tvalid = 1'b0;
        tx_tlast = 1'b0;
        tx_tuser = 1'b0;
    endtask

    task automatic make_payload(input int n, output logic [7:0] q[$]);
        logic [7:0] b;
        q.delete();
        for (int k = 0; k < n; k++) begin
            next_byte(b);
            q.push_back(b);
        end
    endtask

    task automatic check_good_frame(input logic [7:0] pay[$]);
        logic [7:0] exp_q[$];
        model_frame(pay, exp_q);
        check_len("xgmii_txd frame byte count", 16'(rx_q.size()), 16'(exp_q.size() + 7));
        for (int k = 0; k < 6; k++) begin
            check_byte($sformatf("xgmii_txd preamble byte %0d", k), rx_q[k], `ETH_PRE);
        end
        check_byte("xgmii_txd sfd", rx_q[6], `ETH_SFD);
        foreach (exp_q[k]) begin
            check_byte($sformatf("xgmii_txd frame byte %0d", k), rx_q[k + 7], exp_q[k]);
        end
        check_len("tx_start_packet pulse count", 16'(start_count), 16'd1);
        // the pulse comes with the first payload word, after seven preamble bytes
        check_len("tx_start_packet byte offset", 16'(start_at), 16'd7);
        check_ctrl("xgmii_txd end control", end_ctrl, CTRL_TERM);
        check_byte("xgmii_txd terminate lane", 8'(end_lane), 8'(exp_q.size() % 4));
        check_byte("stat_tx_pkt_good", {7'd0, end_good}, 8'h01);
        check_byte("stat_tx_pkt_bad", {7'd0, end_bad}, 8'h00);
        check_len("stat_tx_pkt_len", end_len, 16'(exp_q.size()));
    endtask

    task automatic check_bad_frame();
        check_len("tx_start_packet pulse count", 16'(start_count), 16'd1);
        check_len("tx_start_packet byte offset", 16'(start_at), 16'd7);
        check_ctrl("xgmii_txd end control", end_ctrl, CTRL_ERROR);
        check_byte("xgmii_txd error word lane 3", end_word[31:24], `XGMII_TERM);
        check_byte("stat_tx_pkt_bad", {7'd0, end_bad}, 8'h01);
        check_byte("stat_tx_pkt_good", {7'd0, end_good}, 8'h00);
    endtask

    task automatic run_frame(input int n, input bit user, input int drop_at, input bit good);
        logic [7:0] pay[$];
        int         n0;
        make_payload(n, pay);
        n0 = frames_seen;
        send_frame(pay, user, drop_at);
        wait (frames_seen > n0);
        if (good) check_good_frame(pay);
        else check_bad_frame();
    endtask

    task automatic test_idle_after_reset();
        cfg_tx_enable = 1'b0;
        tx_tvalid = 1'b1;
        repeat (20) begin
            @(negedge clk);
            check_byte("xgmii_txc", {4'h0, xgmii_txc}, 8'h0f);
            for (int l = 0; l < 4; l++) begin
                check_ctrl("xgmii_txd lane", xgmii_ctrl_t'(xgmii_txd[l*8 +: 8]), CTRL_IDLE);
            end
            check_byte("tx_tready", {7'd0, tx_tready}, 8'h00);
        end
        tx_tvalid = 1'b0;
        cfg_tx_enable = 1'b1;
        @(negedge clk);
    endtask

    task automatic test_ifg(input logic [7:0] ifg);
        logic [7:0] p1[$];
        logic [7:0] p2[$];
        int         n0;
        int         lo;
        cfg_tx_ifg = ifg;
        lo = (ifg > `ETH_MIN_IFG) ? int'(ifg) : `ETH_MIN_IFG;
        make_payload(61, p1);
        make_payload(62, p2);
        n0 = frames_seen;
        send_frame(p1, 1'b0, -1);
        send_frame(p2, 1'b0, -1);
        wait (frames_seen > n0 + 1);
        if (last_gap < lo || last_gap >= lo + 4) begin
            fail_now($sformatf("idle gap of %0d bytes is outside [%0d, %0d) for cfg_tx_ifg %0d",
                               last_gap, lo, lo + 4, ifg));
        end
        check_good_frame(p2);
    endtask

    initial begin
        clk = 1'b0;
        reset_crc = 1'b1;
        tx_tdata = '0;
        tx_tkeep = '0;
        tx_tvalid = 1'b0;
        tx_tlast = 1'b0;
        tx_tuser = 1'b0;
        cfg_tx_ifg = 8'd12;
        cfg_tx_enable = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset_crc = 1'b0;
        test_idle_after_reset();
        run_frame(20, 1'b0, -1, 1'b1);
        for (int n = 61; n <= 64; n++) begin
            run_frame(n, 1'b0, -1, 1'b1);
        end
        run_frame(64, 1'b1, -1, 1'b0);
        // valid drops on the sixth beat
        run_frame(64, 1'b0, 5, 1'b0);
        test_ifg(8'd8);
        test_ifg(8'd20);
        $display("=== PASS ===");
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * PERIOD);
        $display("watchdog expired before all frames completed");
        $display("=== FAIL ===");
        $fatal(1, "timeout");
    end

endmodule

// ==== sim/xgmii_tx_assertions.sv ====
// concurrent checks on idle txc, statistics strobes and the start pulse, with its bind
module xgmii_tx_assertions import eth_tx_pkg::*; (
    input logic      clk,
    input logic      reset_crc,
    input tx_state_t state,
    input logic [3:0] xgmii_txc,
    input logic      tx_start_packet,
    input logic      stat_tx_pkt_good,
    input logic      stat_tx_pkt_bad
);

    idle_txc: assert property (@(posedge clk) disable iff (reset_crc)
        state == IDLE |-> xgmii_txc == 4'hf)
        else $error("xgmii_txc not all control lanes while the sequencer is idle");

    // a frame is either good or bad
    stat_exclusive: assert property (@(posedge clk) disable iff (reset_crc)
        !(stat_tx_pkt_good && stat_tx_pkt_bad))
        else $error("good and bad statistics strobes high together");

    start_one_cycle: assert property (@(posedge clk) disable iff (reset_crc)
        tx_start_packet |=> !tx_start_packet)
        else $error("tx_start_packet wider than one cycle");

endmodule

bind xgmii_tx xgmii_tx_assertions u_assert (
    .clk              (clk),
    .reset_crc        (reset_crc),
    .state            (u_fsm.state_reg),
    .xgmii_txc        (xgmii_txc),
    .tx_start_packet  (tx_start_packet),
    .stat_tx_pkt_good (stat_tx_pkt_good),
    .stat_tx_pkt_bad  (stat_tx_pkt_bad)
);

// ==== hw/xgmii_tx.sv ====
// 32-bit XGMII Ethernet transmitter top: frame sequencer and FCS generator on one interface
module xgmii_tx (
    input  logic        clk,
    input  logic        reset_crc,
    input  logic [31:0] tx_tdata,
    input  logic [3:0]  tx_tkeep,
    input  logic        tx_tvalid,
    input  logic        tx_tlast,
    input  logic        tx_tuser,
    output logic        tx_tready,
    input  logic [7:0]  cfg_tx_ifg,
    input  logic        cfg_tx_enable,
    output logic [31:0] xgmii_txd,
    output logic [3:0]  xgmii_txc,
    output logic        tx_start_packet,
    output logic        stat_tx_pkt_good,
    output logic        stat_tx_pkt_bad,
    output logic [15:0] stat_tx_pkt_len
);

    fcs_if fcs ();

    // stream ports match by name
    eth_tx_fsm u_fsm (
        .*,
        .fcs (fcs.seq)
    );

    eth_fcs_gen u_fcs (
        .clk       (clk),
        .reset_crc (reset_crc),
        .fcs       (fcs.gen)
    );

endmodule

// ==== hw/eth_tx_fsm.sv ====
// frame sequencer: stream intake, staging, zero padding, FCS insertion, IFG and statistics
`include "eth_tx_consts.svh"

module eth_tx_fsm import eth_tx_pkg::*; (
    input  logic        clk,
    input  logic        reset_crc,
    input  logic [31:0] tx_tdata,
    input  logic [3:0]  tx_tkeep,
    input  logic        tx_tvalid,
    input  logic        tx_tlast,
    input  logic        tx_tuser,
    output logic        tx_tready,
    input  logic [7:0]  cfg_tx_ifg,
    input  logic        cfg_tx_enable,
    output logic [31:0] xgmii_txd,
    output logic [3:0]  xgmii_txc,
    output logic        tx_start_packet,
    output logic        stat_tx_pkt_good,
    output logic        stat_tx_pkt_bad,
    output logic [15:0] stat_tx_pkt_len,
    fcs_if.seq          fcs
);

    // payload bytes still owed before the minimum length is reached
    localparam int MIN_CNT = `ETH_MIN_FRAME_LEN - 4;
    localparam int MIN_W = $clog2(MIN_CNT + 1);

    tx_state_t   state_reg;
    tx_state_t   state_next;
    logic        crc_init;
    logic        crc_update;
    logic [31:0] s_tdata_reg;
    logic [31:0] s_tdata_next;
    lane_empty_t s_empty_reg;
    lane_empty_t s_empty_next;
    logic        frame_reg;
    logic        frame_next;
    logic        frame_error_reg;
    logic        frame_error_next;
    logic [MIN_W-1:0] min_count_reg;
    logic [MIN_W-1:0] min_count_next;
    logic [15:0] frame_len_reg;
    logic [15:0] frame_len_next;
    logic [7:0]  ifg_count_reg;
    logic [7:0]  ifg_count_next;
    logic        tready_next;
    logic [31:0] txd_next;
    logic [3:0]  txc_next;
    logic        start_next;
    logic        good_next;
    logic        bad_next;
    logic [15:0] len_next;
    logic [31:0] tdata_masked;
    lane_empty_t keep_empty;
    lane_empty_t pad_empty;
    lane_empty_t idle_lanes;
    logic [7:0]  ifg_min;

    function automatic lane_empty_t keep2empty(input logic [3:0] keep);
        lane_empty_t e;
        casez (keep)
            4'b1111: e = 2'd0;
            4'b0111: e = 2'd1;
            4'b?011: e = 2'd2;
            default: e = 2'd3;
        endcase
        return e;
    endfunction

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            tdata_masked[i*8 +: 8] = tx_tkeep[i] ? tx_tdata[i*8 +: 8] : 8'd0;
        end
    end

    assign keep_empty = keep2empty(tx_tkeep);
    assign pad_empty = lane_empty_t'(MIN_W'(4) - min_count_reg);
    // idle lanes after the terminate character
    assign idle_lanes = s_empty_reg - 2'd1;
    assign ifg_min = (cfg_tx_ifg > 8'(`ETH_MIN_IFG)) ? cfg_tx_ifg : 8'(`ETH_MIN_IFG);

    assign fcs.crc_init = crc_init;
    assign fcs.crc_update = crc_update;
    assign fcs.stage_data = s_tdata_reg;
    assign fcs.stage_empty = s_empty_reg;

    always_comb begin
        state_next = state_reg;
        crc_init = 1'b0;
        crc_update = 1'b0;
        s_tdata_next = s_tdata_reg;
        s_empty_next = s_empty_reg;
        frame_next = frame_reg;
        frame_error_next = frame_error_reg;
        min_count_next = (min_count_reg > MIN_W'(4)) ? min_count_reg - MIN_W'(4) : '0;
        frame_len_next = frame_len_reg + 16'd4;
        ifg_count_next = ifg_count_reg;
        tready_next = 1'b0;
        txd_next = {4{CTRL_IDLE}};
        txc_next = 4'hf;
        start_next = 1'b0;
        good_next = 1'b0;
        bad_next = 1'b0;
        len_next = '0;

        if (tx_tvalid && tx_tready) begin
            frame_next = !tx_tlast;
        end

        case (state_reg)
            IDLE: begin
                crc_init = 1'b1;
                frame_error_next = 1'b0;
                min_count_next = MIN_W'(MIN_CNT);
                frame_len_next = '0;
                s_tdata_next = tdata_masked;
                s_empty_next = keep_empty;
                if (tx_tvalid && cfg_tx_enable) begin
                    txd_next = {{3{`ETH_PRE}}, CTRL_START};
                    txc_next = 4'b0001;
                    tready_next = 1'b1;
                    state_next = PREAMBLE;
                end
            end
            PREAMBLE: begin
                crc_init = 1'b1;
                frame_len_next = '0;
                s_tdata_next = tdata_masked;
                s_empty_next = keep_empty;
                txd_next = {`ETH_SFD, {3{`ETH_PRE}}};
                txc_next = 4'b0000;
                tready_next = 1'b1;
                state_next = PAYLOAD;
            end
            PAYLOAD: begin
                crc_update = 1'b1;
                tready_next = 1'b1;
                start_next = (frame_len_reg == '0);
                txd_next = s_tdata_reg;
                txc_next = 4'b0000;
                s_tdata_next = tdata_masked;
                s_empty_next = keep_empty;
                // short frame, widen the last beat up to the minimum
                if (min_count_reg > MIN_W'(4)) begin
                    s_empty_next = 2'd0;
                end else if (min_count_reg != '0 && keep_empty > pad_empty) begin
                    s_empty_next = pad_empty;
                end
                if (!tx_tvalid || tx_tlast) begin
                    // underflow keeps draining the rest of the frame
                    tready_next = frame_next;
                    frame_error_next = !tx_tvalid || tx_tuser;
                    state_next = (min_count_reg > MIN_W'(4)) ? PAD : FCS_1;
                end
            end
            PAD: begin
                crc_update = 1'b1;
                tready_next = frame_next;
                txd_next = s_tdata_reg;
                txc_next = 4'b0000;
                s_tdata_next = '0;
                s_empty_next = 2'd0;
                if (min_count_reg <= MIN_W'(4)) begin
                    s_empty_next = pad_empty;
                    state_next = FCS_1;
                end
            end
            FCS_1: begin
                crc_update = 1'b1;
                tready_next = frame_next;
                txd_next = fcs.fcs_word_0;
                txc_next = 4'b0000;
                ifg_count_next = ifg_min - 8'(idle_lanes);
                state_next = frame_error_reg ? ERR : FCS_2;
            end
            FCS_2: begin
                tready_next = frame_next;
                txd_next = fcs.fcs_word_1;
                txc_next = fcs.fcs_ctrl_1;
                frame_len_next = frame_len_reg + 16'(3'd4 - 3'(s_empty_reg));
                if (s_empty_reg == 2'd0) begin
                    state_next = FCS_3;
                end else begin
                    good_next = 1'b1;
                    len_next = frame_len_next;
                    state_next = IFG;
                end
            end
            FCS_3: begin
                tready_next = frame_next;
                txd_next = {{3{CTRL_IDLE}}, CTRL_TERM};
                good_next = 1'b1;
                len_next = frame_len_reg;
                state_next = IFG;
            end
            ERR: begin
                tready_next = frame_next;
                txd_next = {CTRL_TERM, {3{CTRL_ERROR}}};
                ifg_count_next = ifg_min;
                bad_next = 1'b1;
                len_next = frame_len_reg;
                state_next = IFG;
            end
            IFG: begin
                tready_next = frame_next;
                ifg_count_next = (ifg_count_reg > 8'd4) ? ifg_count_reg - 8'd4 : 8'd0;
                if (ifg_count_next == 8'd0 && !frame_next) begin
                    state_next = IDLE;
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        s_tdata_reg <= s_tdata_next;
        s_empty_reg <= s_empty_next;
        frame_error_reg <= frame_error_next;
        min_count_reg <= min_count_next;
        frame_len_reg <= frame_len_next;
        stat_tx_pkt_len <= len_next;
        if (reset_crc) begin
            state_reg <= IDLE;
            frame_reg <= 1'b0;
            ifg_count_reg <= '0;
            tx_tready <= 1'b0;
            xgmii_txd <= {4{CTRL_IDLE}};
            xgmii_txc <= 4'hf;
            tx_start_packet <= 1'b0;
            stat_tx_pkt_good <= 1'b0;
            stat_tx_pkt_bad <= 1'b0;
        end else begin
            state_reg <= state_next;
            frame_reg <= frame_next;
            ifg_count_reg <= ifg_count_next;
            tx_tready <= tready_next;
            xgmii_txd <= txd_next;
            xgmii_txc <= txc_next;
            tx_start_packet <= start_next;
            stat_tx_pkt_good <= good_next;
            stat_tx_pkt_bad <= bad_next;
        end
    end

endmodule

// ==== hw/eth_fcs_gen.sv ====
// running CRC-32 with one- to four-lane update networks and the two closing FCS words
`include "eth_tx_consts.svh"

module eth_fcs_gen import eth_tx_pkg::*; (
    input  logic clk,
    input  logic reset_crc,
    fcs_if.gen   fcs
);

    // [3] is the running CRC, [0]..[2] hold it advanced by one to three lanes
    logic [31:0] crc_reg [4];
    logic [31:0] crc_next [4];

    function automatic logic [31:0] crc_step(input logic [31:0] crc, input logic [31:0] data,
                                             input int bits);
        logic [31:0] c;
        c = crc;
        for (int i = 0; i < 32; i++) begin
            if (i < bits) begin
                c = (c >> 1) ^ ((c[0] ^ data[i]) ? `ETH_CRC_POLY : 32'd0);
            end
        end
        return c;
    endfunction

    for (genvar n = 0; n < 4; n++) begin : g_lane
        assign crc_next[n] = crc_step(crc_reg[3], fcs.stage_data, 8 * (n + 1));
    end

    always_ff @(posedge clk) begin
        if (reset_crc) begin
            for (int i = 0; i < 4; i++) begin
                crc_reg[i] <= '1;
            end
        end else begin
            for (int i = 0; i < 3; i++) begin
                crc_reg[i] <= crc_next[i];
            end
            if (fcs.crc_init) begin
                crc_reg[3] <= '1;
            end else if (fcs.crc_update) begin
                crc_reg[3] <= crc_next[3];
            end
        end
    end

    // word 0 closes the data, word 1 carries the rest of the FCS and the terminate
    always_comb begin
        case (fcs.stage_empty)
            2'd3: begin
                fcs.fcs_word_0 = {~crc_next[0][23:0], fcs.stage_data[7:0]};
                fcs.fcs_word_1 = {CTRL_IDLE, CTRL_IDLE, CTRL_TERM, ~crc_reg[0][31:24]};
                fcs.fcs_ctrl_1 = 4'b1110;
            end
            2'd2: begin
                fcs.fcs_word_0 = {~crc_next[1][15:0], fcs.stage_data[15:0]};
                fcs.fcs_word_1 = {CTRL_IDLE, CTRL_TERM, ~crc_reg[1][31:16]};
                fcs.fcs_ctrl_1 = 4'b1100;
            end
            2'd1: begin
                fcs.fcs_word_0 = {~crc_next[2][7:0], fcs.stage_data[23:0]};
                fcs.fcs_word_1 = {CTRL_TERM, ~crc_reg[2][31:8]};
                fcs.fcs_ctrl_1 = 4'b1000;
            end
            default: begin
                // full last beat, terminate goes out one word later
                fcs.fcs_word_0 = fcs.stage_data;
                fcs.fcs_word_1 = ~crc_reg[3];
                fcs.fcs_ctrl_1 = 4'b0000;
            end
        endcase
    end

endmodule

// ==== hw/fcs_if.sv ====
// CRC control, staged beat and closing FCS words, with seq and gen modports
interface fcs_if import eth_tx_pkg::*; ();

    logic        crc_init;
    logic        crc_update;
    logic [31:0] stage_data;
    lane_empty_t stage_empty;
    logic [31:0] fcs_word_0;
    logic [31:0] fcs_word_1;
    logic [3:0]  fcs_ctrl_1;

    modport seq (
        output crc_init, crc_update, stage_data, stage_empty,
        input  fcs_word_0, fcs_word_1, fcs_ctrl_1
    );

    modport gen (
        input  crc_init, crc_update, stage_data, stage_empty,
        output fcs_word_0, fcs_word_1, fcs_ctrl_1
    );

endinterface

// ==== hw/eth_tx_pkg.sv ====
// sequencer state enum, XGMII control-character enum and lane-empty type
`include "eth_tx_consts.svh"

package eth_tx_pkg;

    typedef enum logic [3:0] {
        IDLE,
        PREAMBLE,
        PAYLOAD,
        PAD,
        FCS_1,
        FCS_2,
        FCS_3,
        ERR,
        IFG
    } tx_state_t;

    typedef enum logic [7:0] {
        CTRL_IDLE  = `XGMII_IDLE,
        CTRL_START = `XGMII_START,
        CTRL_TERM  = `XGMII_TERM,
        CTRL_ERROR = `XGMII_ERROR
    } xgmii_ctrl_t;

    // unused byte lanes at the top of the last beat
    typedef logic [1:0] lane_empty_t;

endpackage

// ==== hw/eth_tx_consts.svh ====
// XGMII control codes, Ethernet framing bytes, frame and gap minimums, CRC-32 polynomial
`ifndef ETH_TX_CONSTS_SVH
`define ETH_TX_CONSTS_SVH

// xgmii control characters
`define XGMII_IDLE  8'h07
`define XGMII_START 8'hfb
`define XGMII_TERM  8'hfd
`define XGMII_ERROR 8'hfe

`define ETH_PRE 8'h55
`define ETH_SFD 8'hd5

// bytes, FCS included
`define ETH_MIN_FRAME_LEN 64
`define ETH_MIN_IFG       12

// 0x04c11db7 bit-reversed, lsb-first shifting
`define ETH_CRC_POLY 32'hedb88320

`endif
